// ==== logic/gci_params.svh ====
`ifndef GCI_PARAMS_SVH
`define GCI_PARAMS_SVH

// Number of device nodes behind the hub
`define GCI_NODE_COUNT 4

// Address and data share one width
`define GCI_DATA_WIDTH 32

`define GCI_PRIO_WIDTH 8

// Interrupt number handed to the CPU
`define GCI_IRQ_NUM_WIDTH 6

// Bytes of hub info space at the bottom of the window
`define GCI_INFO_SPACE 1024

`endif

// ==== logic/gci_pkg.sv ====
`include "gci_params.svh"

package gci_pkg;

	typedef logic [`GCI_DATA_WIDTH-1:0] addr_t;
	typedef logic [`GCI_DATA_WIDTH-1:0] data_t;
	typedef logic [`GCI_PRIO_WIDTH-1:0] prio_t;

	// 0 is info memory, 1 to 4 the nodes
	typedef logic [2:0] node_id_t;

	typedef logic [`GCI_IRQ_NUM_WIDTH-1:0] irq_num_t;

	// One CPU access in flight
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_WAIT_DEV,	// Request issued, waiting for target ack
		SEQ_WAIT_CPU	// Read data offered to CPU
	} seq_state_t;

	typedef enum logic [1:0] {
		IRQ_IDLE,
		IRQ_PRESENT,	// Winner shown to CPU
		IRQ_ACK			// Ack pulse back to the node
	} irq_state_t;

endpackage

// ==== logic/gci_if.sv ====
`timescale 1ns/10ps
`include "gci_params.svh"

// Announced node table, one entry per node
interface node_info_if import gci_pkg::*; ();
	logic [`GCI_NODE_COUNT-1:0] registered;
	prio_t prio [`GCI_NODE_COUNT];
	addr_t memsize [`GCI_NODE_COUNT];
	logic all_received;	// Every present node has announced

	modport tbl (
		output registered, prio, memsize, all_received
	);

	modport reader (
		input registered, prio, memsize, all_received
	);
endinterface

// Hub side access bus toward info memory and the nodes
interface dev_access_if import gci_pkg::*; ();
	logic [`GCI_NODE_COUNT:0] req;	// Bit 0 info memory, bits 1..4 nodes
	logic rw;						// 1 write, 0 read
	addr_t addr;					// Node local address
	data_t wdata;
	logic [`GCI_NODE_COUNT:0] ack;
	data_t rdata [`GCI_NODE_COUNT+1];

	modport master (
		output req, rw, addr, wdata,
		input ack, rdata
	);

	modport target (
		input req, rw, addr, wdata,
		output ack, rdata
	);
endinterface

// ==== logic/node_info_table.sv ====
`timescale 1ns/10ps
`include "gci_params.svh"

module node_info_table import gci_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic [`GCI_NODE_COUNT-1:0] dev_present,
	input logic [`GCI_NODE_COUNT-1:0] dev_info_valid,
	input prio_t dev_info_priority [`GCI_NODE_COUNT],
	input addr_t dev_info_memsize [`GCI_NODE_COUNT],
	node_info_if.tbl info
);
	logic [`GCI_NODE_COUNT-1:0] registered_q;
	prio_t prio_q [`GCI_NODE_COUNT];
	addr_t memsize_q [`GCI_NODE_COUNT];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			registered_q <= '0;
			for (int i = 0; i < `GCI_NODE_COUNT; i++) begin
				prio_q[i] <= '0;
				memsize_q[i] <= '0;	// Unannounced nodes take no address space
			end
		end else begin
			for (int i = 0; i < `GCI_NODE_COUNT; i++) begin
				if (dev_info_valid[i]) begin
					prio_q[i] <= dev_info_priority[i];	// Priority may change any time
					if (!registered_q[i]) begin
						registered_q[i] <= 1'b1;
						memsize_q[i] <= dev_info_memsize[i];	// First pulse only
					end
				end
			end
		end
	end

	assign info.registered = registered_q;
	assign info.prio = prio_q;
	assign info.memsize = memsize_q;

	// Absent nodes never hold up the CPU
	assign info.all_received = &(~dev_present | registered_q);

	// Region map must not move once a node is in it
	for (genvar i = 0; i < `GCI_NODE_COUNT; i++) begin : g_size_check
		a_memsize_fixed: assert property (
			@(posedge iCLOCK) disable iff (!inRESET)
			registered_q[i] |=> $stable(memsize_q[i])
		);
	end

endmodule

// ==== logic/node_addr_decoder.sv ====
`timescale 1ns/10ps
`include "gci_params.svh"

module node_addr_decoder import gci_pkg::*; (
	node_info_if.reader info,
	input addr_t cpu_addr,
	output node_id_t target_id,
	output addr_t local_addr
);

	// Regions follow the info space back to back in node order
	always_comb begin
		addr_t base;
		addr_t limit;

		target_id = '0;
		local_addr = '0;	// Out of range reads info word 0
		base = addr_t'(`GCI_INFO_SPACE);
		limit = base;
		if (cpu_addr < addr_t'(`GCI_INFO_SPACE)) begin
			local_addr = cpu_addr;
		end else begin
			for (int i = 0; i < `GCI_NODE_COUNT; i++) begin
				limit = base + info.memsize[i];
				if (target_id == '0 && cpu_addr < limit) begin	// Earlier regions missed
					target_id = node_id_t'(i + 1);
					local_addr = cpu_addr - base;
				end
				base = limit;
			end
		end
	end

endmodule

// ==== logic/access_sequencer.sv ====
`timescale 1ns/10ps
`include "gci_params.svh"

module access_sequencer import gci_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic cpu_req,
	input logic cpu_rw,
	input data_t cpu_wdata,
	input logic cpu_rbusy,
	input node_id_t target_id,
	input addr_t local_addr,
	input logic all_received,
	output logic cpu_busy,
	output logic cpu_rvalid,
	output data_t cpu_rdata,
	dev_access_if.master bus
);
	seq_state_t state_q;
	node_id_t target_q;
	logic rw_q;
	logic rvalid_q;
	logic [`GCI_NODE_COUNT:0] req_q;
	addr_t addr_q;
	data_t wdata_q;
	data_t rdata_q;
	logic start;
	logic target_ack;

	assign cpu_busy = !all_received || state_q != SEQ_IDLE;
	assign start = cpu_req && !cpu_busy;
	assign target_ack = bus.ack[target_q];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= SEQ_IDLE;
			target_q <= '0;
			rw_q <= 1'b0;
			rvalid_q <= 1'b0;
			req_q <= '0;
		end else begin
			case (state_q)
				SEQ_IDLE: begin
					if (start) begin
						req_q <= {{`GCI_NODE_COUNT{1'b0}}, 1'b1} << target_id;
						target_q <= target_id;
						rw_q <= cpu_rw;
						state_q <= SEQ_WAIT_DEV;
					end
				end
				SEQ_WAIT_DEV: begin
					req_q <= '0;	// Single cycle strobe
					if (target_ack) begin
						rvalid_q <= 1'b1;
						state_q <= SEQ_WAIT_CPU;
					end
				end
				SEQ_WAIT_CPU: begin
					if (!cpu_rbusy) begin	// CPU took the data
						rvalid_q <= 1'b0;
						state_q <= SEQ_IDLE;
					end
				end
				default: state_q <= SEQ_IDLE;
			endcase
		end
	end

	// Access payload
	always_ff @(posedge iCLOCK) begin
		if (start) begin
			addr_q <= local_addr;
			wdata_q <= cpu_wdata;
		end
		if (state_q == SEQ_WAIT_DEV && target_ack)
			rdata_q <= bus.rdata[target_q];
	end

	assign bus.req = req_q;
	assign bus.rw = rw_q;
	assign bus.addr = addr_q;
	assign bus.wdata = wdata_q;

	assign cpu_rvalid = rvalid_q;
	assign cpu_rdata = rdata_q;

	a_req_onehot: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		$onehot0(bus.req)
	);

	a_req_single: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		(bus.req != '0) |=> (bus.req == '0)
	);

	a_rvalid_state: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		cpu_rvalid |-> state_q == SEQ_WAIT_CPU
	);

endmodule

// ==== logic/hub_info_memory.sv ====
`timescale 1ns/10ps
`include "gci_params.svh"

module hub_info_memory import gci_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	node_info_if.reader info,
	dev_access_if.target bus
);
	logic ack_q;
	data_t rdata_q;
	data_t word;
	logic [7:0] word_idx;

	assign word_idx = bus.addr[9:2];

	// Even words hold sizes, odd words priorities
	always_comb begin
		word = '0;
		for (int k = 0; k < `GCI_NODE_COUNT; k++) begin
			if (word_idx == 8'(2 * k))
				word = info.memsize[k];
			if (word_idx == 8'(2 * k + 1))
				word = data_t'(info.prio[k]);
		end
		if (bus.rw)
			word = '0;	// Read only space
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET)
			ack_q <= 1'b0;
		else
			ack_q <= bus.req[0];	// Fixed one cycle answer
	end

	always_ff @(posedge iCLOCK) begin
		if (bus.req[0])
			rdata_q <= word;
	end

	assign bus.ack[0] = ack_q;
	assign bus.rdata[0] = rdata_q;

endmodule

// ==== logic/irq_priority_arbiter.sv ====
`timescale 1ns/10ps
`include "gci_params.svh"

module irq_priority_arbiter import gci_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	node_info_if.reader info,
	input logic [`GCI_NODE_COUNT-1:0] dev_irq,
	output logic [`GCI_NODE_COUNT-1:0] dev_irq_ack,
	output logic cpu_irq_req,
	output irq_num_t cpu_irq_num,
	input logic cpu_irq_ack
);
	irq_state_t state_q;
	irq_num_t num_q;
	irq_num_t win_num;
	prio_t win_prio;
	logic [`GCI_NODE_COUNT-1:0] pending;

	assign pending = dev_irq & info.registered;

	// Strict compare keeps the lower index on a tie
	always_comb begin
		win_num = '0;
		win_prio = '0;
		for (int i = 0; i < `GCI_NODE_COUNT; i++) begin
			if (pending[i] && (win_num == '0 || info.prio[i] > win_prio)) begin
				win_num = irq_num_t'(i + 1);
				win_prio = info.prio[i];
			end
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= IRQ_IDLE;
			num_q <= '0;
		end else begin
			case (state_q)
				IRQ_IDLE: begin
					if (info.all_received && pending != '0) begin
						num_q <= win_num;
						state_q <= IRQ_PRESENT;
					end
				end
				IRQ_PRESENT: if (cpu_irq_ack) state_q <= IRQ_ACK;
				IRQ_ACK: state_q <= IRQ_IDLE;	// Node drops irq on the ack pulse
				default: state_q <= IRQ_IDLE;
			endcase
		end
	end

	assign cpu_irq_req = state_q == IRQ_PRESENT;
	assign cpu_irq_num = num_q;

	for (genvar i = 0; i < `GCI_NODE_COUNT; i++) begin : g_ack
		assign dev_irq_ack[i] = state_q == IRQ_ACK && num_q == irq_num_t'(i + 1);
	end

	a_irq_num_range: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		cpu_irq_req |-> (cpu_irq_num >= 1 && cpu_irq_num <= `GCI_NODE_COUNT)
	);

endmodule

// ==== logic/gci_hub.sv ====
`timescale 1ns/10ps
`include "gci_params.svh"

module gci_hub import gci_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	// CPU data side
	input logic cpu_req,
	input logic cpu_rw,
	input addr_t cpu_addr,
	input data_t cpu_wdata,
	input logic cpu_rbusy,
	output logic cpu_busy,
	output logic cpu_rvalid,
	output data_t cpu_rdata,
	// CPU interrupt side
	output logic cpu_irq_req,
	output irq_num_t cpu_irq_num,
	input logic cpu_irq_ack,
	// Nodes, index 0 is node 1
	input logic [`GCI_NODE_COUNT-1:0] dev_present,
	input logic [`GCI_NODE_COUNT-1:0] dev_info_valid,
	input prio_t dev_info_priority [`GCI_NODE_COUNT],
	input addr_t dev_info_memsize [`GCI_NODE_COUNT],
	input logic [`GCI_NODE_COUNT-1:0] dev_ack,
	input data_t dev_rdata [`GCI_NODE_COUNT],
	input logic [`GCI_NODE_COUNT-1:0] dev_irq,
	output logic [`GCI_NODE_COUNT-1:0] dev_req,
	output logic dev_rw,
	output addr_t dev_addr,
	output data_t dev_wdata,
	output logic [`GCI_NODE_COUNT-1:0] dev_irq_ack
);
	node_info_if u_info ();
	dev_access_if u_bus ();

	node_id_t target_id;
	addr_t local_addr;

	node_info_table i_node_info_table (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.dev_present(dev_present),
		.dev_info_valid(dev_info_valid),
		.dev_info_priority(dev_info_priority),
		.dev_info_memsize(dev_info_memsize),
		.info(u_info)
	);

	node_addr_decoder i_node_addr_decoder (
		.info(u_info),
		.cpu_addr(cpu_addr),
		.target_id(target_id),
		.local_addr(local_addr)
	);

	access_sequencer i_access_sequencer (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.cpu_req(cpu_req),
		.cpu_rw(cpu_rw),
		.cpu_wdata(cpu_wdata),
		.cpu_rbusy(cpu_rbusy),
		.target_id(target_id),
		.local_addr(local_addr),
		.all_received(u_info.all_received),
		.cpu_busy(cpu_busy),
		.cpu_rvalid(cpu_rvalid),
		.cpu_rdata(cpu_rdata),
		.bus(u_bus)
	);

	hub_info_memory i_hub_info_memory (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.info(u_info),
		.bus(u_bus)
	);

	irq_priority_arbiter i_irq_priority_arbiter (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.info(u_info),
		.dev_irq(dev_irq),
		.dev_irq_ack(dev_irq_ack),
		.cpu_irq_req(cpu_irq_req),
		.cpu_irq_num(cpu_irq_num),
		.cpu_irq_ack(cpu_irq_ack)
	);

	// Node ports sit on bus bits 1..4
	assign dev_req = u_bus.req[`GCI_NODE_COUNT:1];
	assign dev_rw = u_bus.rw;
	assign dev_addr = u_bus.addr;
	assign dev_wdata = u_bus.wdata;
	assign u_bus.ack[`GCI_NODE_COUNT:1] = dev_ack;

	for (genvar i = 0; i < `GCI_NODE_COUNT; i++) begin : g_rdata
		assign u_bus.rdata[i + 1] = dev_rdata[i];
	end

endmodule

// ==== bench/tb_device_model.sv ====
`timescale 1ns/10ps

module tb_device_model import gci_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic req,
	input logic rw,
	input addr_t addr,
	input data_t wdata,
	input logic [1:0] delay,	// Extra ack cycles, taken with the request
	input logic irq_set,
	input logic irq_ack,
	output logic ack,
	output data_t rdata,
	output logic irq
);
	data_t mem [64];
	addr_t addr_q;
	data_t wdata_q;
	logic rw_q;
	logic pend;
	logic [1:0] cnt;

	always @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ack <= 1'b0;
			irq <= 1'b0;
			pend = 1'b0;
			cnt = '0;
		end else begin
			ack <= 1'b0;
			if (req) begin
				pend = 1'b1;
				cnt = delay;
				rw_q = rw;
				addr_q = addr;
				wdata_q = wdata;
			end
			if (pend && cnt == 2'd0) begin
				pend = 1'b0;
				ack <= 1'b1;	// Data valid in the ack cycle
				if (rw_q) begin
					mem[addr_q[7:2]] = wdata_q;
					rdata <= '0;
				end else
					rdata <= mem[addr_q[7:2]];
			end else if (pend)
				cnt = cnt - 2'd1;
			if (irq_ack)
				irq <= 1'b0;	// Dropped on the hub's ack pulse
			else if (irq_set)
				irq <= 1'b1;
		end
	end

endmodule

// ==== bench/tb_gci_hub.sv ====
`timescale 1ns/10ps
`include "gci_params.svh"

module tb_gci_hub import gci_pkg::*; ();
	typedef struct packed {
		logic rw;
		addr_t addr;
		data_t wdata;
		data_t exp;
		logic [3:0] stall;	// Cycles the CPU holds off read data
	} row_t;

	localparam int NUM_ROWS = 21;
	localparam int ACCESS_MAX = 24;	// Busy wait, request, ack delay, longest stall, release
	localparam int TIMEOUT_CYCLES = 2 * NUM_ROWS * ACCESS_MAX + 100;
	localparam int DRIVE_DLY = 10;

	logic iCLOCK, inRESET;
	logic cpu_req, cpu_rw, cpu_rbusy, cpu_busy, cpu_rvalid;
	addr_t cpu_addr;
	data_t cpu_wdata, cpu_rdata;
	logic cpu_irq_req, cpu_irq_ack;
	irq_num_t cpu_irq_num;
	logic [`GCI_NODE_COUNT-1:0] dev_present, dev_info_valid, dev_ack, dev_irq;
	logic [`GCI_NODE_COUNT-1:0] dev_req, dev_irq_ack, irq_fire;
	prio_t dev_info_priority [`GCI_NODE_COUNT];
	addr_t dev_info_memsize [`GCI_NODE_COUNT];
	data_t dev_rdata [`GCI_NODE_COUNT];
	logic dev_rw;
	addr_t dev_addr;
	data_t dev_wdata;
	logic [1:0] ack_delay;
	logic [7:0] lfsr = 8'd69;
	int errors = 0;
	int checks = 0;
	int cycle_cnt = 0;
	int order_start [3] = '{2, 4, 1};
	int order_update [3] = '{1, 2, 4};

	// Regions 0x400 node 1, 0x500 node 2, 0x700 node 4, end at 0x780
	row_t rows [NUM_ROWS] = '{
		'{1'b1, 32'h400, 32'h1111_0001, 32'h0, 4'd0},
		'{1'b1, 32'h4FC, 32'h1111_00FC, 32'h0, 4'd0},
		'{1'b1, 32'h500, 32'h2222_0001, 32'h0, 4'd1},
		'{1'b1, 32'h6FC, 32'h2222_01FC, 32'h0, 4'd0},
		'{1'b1, 32'h700, 32'h4444_0001, 32'h0, 4'd0},
		'{1'b1, 32'h77C, 32'h4444_007C, 32'h0, 4'd0},
		'{1'b0, 32'h400, 32'h0, 32'h1111_0001, 4'd0},
		'{1'b0, 32'h4FC, 32'h0, 32'h1111_00FC, 4'd0},
		'{1'b0, 32'h500, 32'h0, 32'h2222_0001, 4'd0},
		'{1'b0, 32'h6FC, 32'h0, 32'h2222_01FC, 4'd2},
		'{1'b0, 32'h700, 32'h0, 32'h4444_0001, 4'd0},
		'{1'b0, 32'h77C, 32'h0, 32'h4444_007C, 4'd6},
		'{1'b0, 32'h000, 32'h0, 32'h100, 4'd0},	// Info words from here
		'{1'b0, 32'h004, 32'h0, 32'd5, 4'd0},
		'{1'b0, 32'h008, 32'h0, 32'h200, 4'd0},
		'{1'b0, 32'h00C, 32'h0, 32'd9, 4'd1},
		'{1'b0, 32'h010, 32'h0, 32'h0, 4'd0},
		'{1'b0, 32'h018, 32'h0, 32'h80, 4'd0},
		'{1'b0, 32'h01C, 32'h0, 32'd9, 4'd3},
		'{1'b0, 32'h020, 32'h0, 32'h0, 4'd0},
		'{1'b0, 32'h780, 32'h0, 32'h100, 4'd0}	// Past all regions
	};

	gci_hub i_gci_hub (.*);

	for (genvar n = 0; n < `GCI_NODE_COUNT; n++) begin : g_node
		tb_device_model i_node (
			.iCLOCK(iCLOCK), .inRESET(inRESET), .req(dev_req[n]), .rw(dev_rw),
			.addr(dev_addr), .wdata(dev_wdata), .delay(ack_delay),
			.irq_set(irq_fire[n]), .irq_ack(dev_irq_ack[n]),
			.ack(dev_ack[n]), .rdata(dev_rdata[n]), .irq(dev_irq[n])
		);
	end

	initial begin
		iCLOCK = 1'b0;
		forever #50 iCLOCK = ~iCLOCK;
	end

	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};	// x^8+x^6+x^5+x^4+1
	endfunction

	task automatic random_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	// Node select and local address in the fixed region map
	task automatic region_lookup(input addr_t a, output logic [3:0] sel, output addr_t local_a);
		sel = '0;
		local_a = '0;
		if (a >= 32'h400 && a < 32'h500) begin
			sel = 4'b0001;
			local_a = a - 32'h400;
		end else if (a >= 32'h500 && a < 32'h700) begin
			sel = 4'b0010;
			local_a = a - 32'h500;
		end else if (a >= 32'h700 && a < 32'h780) begin
			sel = 4'b1000;
			local_a = a - 32'h700;
		end
	endtask

	task automatic check_value(input string what, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge iCLOCK);
		#DRIVE_DLY;
	endtask

	task automatic announce(input int node, input prio_t prio, input addr_t size);
		dev_info_priority[node] = prio;
		dev_info_memsize[node] = size;
		dev_info_valid[node] = 1'b1;
		next_cycle();
		dev_info_valid[node] = 1'b0;
	endtask

	task automatic do_access(input row_t r, input string tag);
		logic [7:0] rnd;
		data_t held;
		logic [3:0] sel;
		addr_t local_a;
		while (cpu_busy)
			next_cycle();
		random_bits(2, rnd);
		ack_delay = rnd[1:0];
		cpu_req = 1'b1;
		cpu_rw = r.rw;
		cpu_addr = r.addr;
		cpu_wdata = r.wdata;
		cpu_rbusy = (r.stall != 4'd0);
		next_cycle();
		cpu_req = 1'b0;
		region_lookup(r.addr, sel, local_a);	// Request cycle on the node side
		check_value({tag, " dev_req"}, data_t'(dev_req), data_t'(sel));
		if (sel != '0) begin
			check_value({tag, " dev_addr"}, dev_addr, local_a);
			check_value({tag, " dev_rw"}, data_t'(dev_rw), data_t'(r.rw));
			if (r.rw)
				check_value({tag, " dev_wdata"}, dev_wdata, r.wdata);
		end
		while (!cpu_rvalid)
			next_cycle();
		check_value({tag, " rdata"}, cpu_rdata, r.exp);
		held = cpu_rdata;
		repeat (r.stall) begin	// Data must hold while the CPU stalls
			next_cycle();
			check_value({tag, " stalled rvalid"}, data_t'(cpu_rvalid), 32'd1);
			check_value({tag, " stalled rdata"}, cpu_rdata, held);
			check_value({tag, " stalled busy"}, data_t'(cpu_busy), 32'd1);
		end
		cpu_rbusy = 1'b0;
		next_cycle();
		check_value({tag, " rvalid release"}, data_t'(cpu_rvalid), 32'd0);
	endtask

	task automatic irq_round(input int order [3]);
		logic [3:0] onehot;
		irq_fire = 4'b1011;	// Nodes 1, 2 and 4 together
		next_cycle();
		irq_fire = '0;
		for (int k = 0; k < 3; k++) begin
			while (!cpu_irq_req)
				next_cycle();
			check_value("cpu_irq_num", data_t'(cpu_irq_num), data_t'(order[k]));
			cpu_irq_ack = 1'b1;
			next_cycle();
			cpu_irq_ack = 1'b0;
			onehot = 4'b0001 << (order[k] - 1);
			check_value("dev_irq_ack", data_t'(dev_irq_ack), data_t'(onehot));
		end
	endtask

	initial begin
		{inRESET, cpu_req, cpu_rw, cpu_rbusy, cpu_irq_ack} = '0;
		cpu_addr = '0;
		cpu_wdata = '0;
		dev_present = 4'b1011;	// Node 3 absent
		dev_info_valid = '0;
		irq_fire = '0;
		ack_delay = '0;
		for (int i = 0; i < `GCI_NODE_COUNT; i++) begin
			dev_info_priority[i] = '0;
			dev_info_memsize[i] = '0;
		end
		repeat (3) @(posedge iCLOCK);
		#DRIVE_DLY;
		inRESET = 1'b1;
		check_value("busy after reset", data_t'(cpu_busy), 32'd1);
		check_value("rvalid after reset", data_t'(cpu_rvalid), 32'd0);
		check_value("irq_req after reset", data_t'(cpu_irq_req), 32'd0);
		check_value("dev_req after reset", data_t'(dev_req), 32'd0);
		check_value("dev_irq_ack after reset", data_t'(dev_irq_ack), 32'd0);
		announce(0, 8'd5, 32'h100);
		announce(1, 8'd9, 32'h200);
		repeat (3) next_cycle();
		check_value("busy before node 4", data_t'(cpu_busy), 32'd1);
		announce(3, 8'd9, 32'h80);
		check_value("busy after announce", data_t'(cpu_busy), 32'd0);
		for (int i = 0; i < NUM_ROWS; i++)
			do_access(rows[i], $sformatf("row %0d", i));
		irq_round(order_start);
		announce(0, 8'd12, 32'h40);	// Priority changes, size stays
		irq_round(order_update);
		for (int i = 6; i < 12; i++)
			do_access(rows[i], $sformatf("reread row %0d", i));
		do_access(row_t'{1'b0, 32'h004, 32'h0, 32'd12, 4'd0}, "node 1 new prio");
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge iCLOCK);
			cycle_cnt++;
		end
		$display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+logic
logic/gci_pkg.sv
logic/gci_if.sv
logic/node_info_table.sv
logic/node_addr_decoder.sv
logic/access_sequencer.sv
logic/hub_info_memory.sv
logic/irq_priority_arbiter.sv
logic/gci_hub.sv
bench/tb_device_model.sv
bench/tb_gci_hub.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the gci_hub testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_gci_hub \
	--Mdir obj_dir -o sim_gci_hub
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_gci_hub)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1
